//--- source/be_checker_pkg.sv
// Shared constants and types of the issue checker
// Imported by the dependency tracker, the next-PC tracker, the detector and the top

package be_checker_pkg;

   // Architectural register address width (x0..x31, f0..f31)
   localparam int reg_addr_width_gp = 5;

   // Tracked producer stages
   // index 0 is EX1, 1 is EX2, 2 is IWB
   localparam int dep_stages_gp = 3;

   // Fixed-size RV instructions, no compressed support
   localparam int instr_bytes_gp = 4;

   // Writeback class of an instruction in flight
   // Determines in which stage its result becomes forwardable
   typedef enum logic [2:0] {
      // No register written, or bubble
      wb_none    = 3'd0,
      // Integer ALU result, forwardable from EX1 on
      wb_int_alu = 3'd1,
      // Integer multiply, ready after EX1
      wb_int_mul = 3'd2,
      // Integer load, ready after EX2
      wb_int_mem = 3'd3,
      // FP load, ready after EX2
      wb_fp_mem  = 3'd4,
      // FP arithmetic, ready only after IWB
      wb_fp_alu  = 3'd5
   } wb_class_e;

endpackage : be_checker_pkg

//--- source/be_dep_tracker.sv
// Records destination register and writeback class of dispatched instructions
// Three stage shift register covering EX1, EX2 and IWB, cleared on pipe poison

`timescale 1ns/100ps

module be_dep_tracker (
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,

   // Valid dispatch out of ISD
   input  logic                                      commit_i,
   // Pipe poison, drops every tracked instruction
   input  logic                                      flush_i,

   // Fields of the instruction leaving ISD
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] rd_addr_i,
   input  be_checker_pkg::wb_class_e                 wb_class_i,

   // Per stage status, index 0 is EX1
   output logic [be_checker_pkg::reg_addr_width_gp-1:0]
                                                     dep_rd_addr_o [be_checker_pkg::dep_stages_gp],
   output be_checker_pkg::wb_class_e                 dep_class_o [be_checker_pkg::dep_stages_gp]
);

   import be_checker_pkg::*;

   logic [reg_addr_width_gp-1:0] rd_addr_q [dep_stages_gp];
   wb_class_e                    class_q   [dep_stages_gp];
   wb_class_e                    class_in;

   // Bubble enters EX1 when nothing is dispatched
   assign class_in = commit_i ? wb_class_i : wb_none;

   // Class decides whether a stage holds a real producer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < dep_stages_gp; i++) begin
            class_q[i] <= wb_none;
         end
      end else if (flush_i) begin
         // Poisoned instructions never write back
         for (int i = 0; i < dep_stages_gp; i++) begin
            class_q[i] <= wb_none;
         end
      end else begin
         class_q[0] <= class_in;
         for (int i = 1; i < dep_stages_gp; i++) begin
            class_q[i] <= class_q[i-1];
         end
      end
   end

   // Destination address only meaningful alongside a valid class
   always_ff @(posedge clk_i) begin
      rd_addr_q[0] <= rd_addr_i;
      for (int i = 1; i < dep_stages_gp; i++) begin
         rd_addr_q[i] <= rd_addr_q[i-1];
      end
   end

   always_comb begin
      for (int i = 0; i < dep_stages_gp; i++) begin
         dep_rd_addr_o[i] = rd_addr_q[i];
         dep_class_o[i]   = class_q[i];
      end
   end

endmodule : be_dep_tracker

//--- source/be_npc_tracker.sv
// Expected PC of the next instruction to issue
// Advances on each committed dispatch, following taken branches

`timescale 1ns/100ps

module be_npc_tracker #(
   parameter int                       vaddr_width_p    = 39,
   parameter logic [vaddr_width_p-1:0] pc_entry_point_p = '0
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // Valid dispatch out of ISD
   input  logic                     commit_i,

   // PC and branch outcome of the committing instruction
   input  logic [vaddr_width_p-1:0] pc_i,
   input  logic                     br_taken_i,
   input  logic [vaddr_width_p-1:0] br_tgt_i,

   output logic [vaddr_width_p-1:0] expected_npc_o
);

   import be_checker_pkg::*;

   logic [vaddr_width_p-1:0] npc_q;
   logic [vaddr_width_p-1:0] npc_seq;

   // Fall-through address
   assign npc_seq = pc_i + vaddr_width_p'(instr_bytes_gp);

   // Holds its value while ISD is blocked or poisoned
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         npc_q <= pc_entry_point_p;
      end else if (commit_i) begin
         npc_q <= br_taken_i ? br_tgt_i : npc_seq;
      end
   end

   assign expected_npc_o = npc_q;

endmodule : be_npc_tracker

//--- source/be_detector.sv
// Issue hazard detector, purely combinational
// Decides dispatch of the ISD instruction and drives the poison and roll controls

`timescale 1ns/100ps

module be_detector #(
   parameter int vaddr_width_p = 39
) (
   input  logic rst_n_i,

   // ISD instruction
   input  logic                                         isd_v_i,
   input  logic [vaddr_width_p-1:0]                     isd_pc_i,
   input  logic                                         isd_irs1_v_i,
   input  logic                                         isd_irs2_v_i,
   input  logic                                         isd_frs1_v_i,
   input  logic                                         isd_frs2_v_i,
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] isd_rs1_addr_i,
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] isd_rs2_addr_i,

   // Producers in EX1, EX2, IWB
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0]
                                         dep_rd_addr_i [be_checker_pkg::dep_stages_gp],
   input  be_checker_pkg::wb_class_e     dep_class_i [be_checker_pkg::dep_stages_gp],

   input  logic [vaddr_width_p-1:0]      expected_npc_i,
   // Structural hazard, memory ops need the MMU
   input  logic                          mmu_cmd_rdy_i,

   // Late events from the memory pipe
   input  logic                          mem3_cache_miss_v_i,
   input  logic                          mem3_exception_v_i,
   input  logic                          mem3_ret_v_i,

   // Pipe control
   output logic                          chk_dispatch_v_o,
   output logic                          chk_roll_o,
   output logic                          chk_psn_isd_o,
   output logic                          chk_psn_ex_o,
   output logic                          isd_commit_o
);

   import be_checker_pkg::*;

   logic [dep_stages_gp-1:0] rs1_match;
   logic [dep_stages_gp-1:0] rs2_match;
   // Producer result not yet forwardable, per stage
   logic [dep_stages_gp-1:0] int_busy;
   logic [dep_stages_gp-1:0] fp_busy;
   logic [dep_stages_gp-1:0] stage_haz;
   logic                     dhaz_v;
   logic                     shaz_v;
   logic                     mispredict_v;
   logic                     mem3_flush_v;

   always_comb begin
      for (int i = 0; i < dep_stages_gp; i++) begin
         // x0 is hardwired, never a dependency
         rs1_match[i] = (isd_rs1_addr_i != '0) & (isd_rs1_addr_i == dep_rd_addr_i[i]);
         rs2_match[i] = (isd_rs2_addr_i != '0) & (isd_rs2_addr_i == dep_rd_addr_i[i]);
      end

      // EX1 waits on mul and loads, plus any FP producer
      int_busy[0] = (dep_class_i[0] == wb_int_mul) | (dep_class_i[0] == wb_int_mem);
      fp_busy[0]  = (dep_class_i[0] == wb_fp_mem) | (dep_class_i[0] == wb_fp_alu);
      // EX2 integer load still outstanding
      int_busy[1] = (dep_class_i[1] == wb_int_mem);
      fp_busy[1]  = (dep_class_i[1] == wb_fp_mem) | (dep_class_i[1] == wb_fp_alu);
      // IWB only FP arithmetic left
      int_busy[2] = 1'b0;
      fp_busy[2]  = (dep_class_i[2] == wb_fp_alu);

      for (int i = 0; i < dep_stages_gp; i++) begin
         stage_haz[i] = (int_busy[i] & ((isd_irs1_v_i & rs1_match[i])
                                      | (isd_irs2_v_i & rs2_match[i])))
                      | (fp_busy[i]  & ((isd_frs1_v_i & rs1_match[i])
                                      | (isd_frs2_v_i & rs2_match[i])));
      end
   end

   assign dhaz_v = |stage_haz;
   assign shaz_v = ~mmu_cmd_rdy_i;

   // Wrong path instruction reached ISD
   assign mispredict_v = isd_v_i & (isd_pc_i != expected_npc_i);
   assign mem3_flush_v = mem3_cache_miss_v_i | mem3_exception_v_i | mem3_ret_v_i;

   assign chk_dispatch_v_o = ~(dhaz_v | shaz_v);
   // Miss replays from the missing load
   assign chk_roll_o       = mem3_cache_miss_v_i;
   // Both poisons forced during reset
   assign chk_psn_isd_o    = ~rst_n_i | mispredict_v | mem3_flush_v;
   assign chk_psn_ex_o     = ~rst_n_i | mem3_flush_v;

   // Instruction actually enters EX1
   assign isd_commit_o = chk_dispatch_v_o & isd_v_i & ~chk_psn_isd_o;

endmodule : be_detector

//--- source/be_checker_top.sv
// Issue checker of the in-order back end
// Dependency tracker and next-PC register feed the combinational detector

`timescale 1ns/100ps

module be_checker_top #(
   parameter int                       vaddr_width_p    = 39,
   parameter logic [vaddr_width_p-1:0] pc_entry_point_p = vaddr_width_p'('h8000_0000)
) (
   input  logic                                         clk_i,
   input  logic                                         rst_n_i,

   // ISD instruction fields, held stable by the front end while blocked
   input  logic                                         isd_v_i,
   input  logic [vaddr_width_p-1:0]                     isd_pc_i,
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] isd_rs1_addr_i,
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] isd_rs2_addr_i,
   input  logic                                         isd_irs1_v_i,
   input  logic                                         isd_irs2_v_i,
   input  logic                                         isd_frs1_v_i,
   input  logic                                         isd_frs2_v_i,
   input  logic [be_checker_pkg::reg_addr_width_gp-1:0] isd_rd_addr_i,
   input  be_checker_pkg::wb_class_e                    isd_wb_class_i,
   input  logic                                         isd_br_taken_i,
   input  logic [vaddr_width_p-1:0]                     isd_br_tgt_i,

   input  logic                                         mmu_cmd_rdy_i,
   input  logic                                         mem3_cache_miss_v_i,
   input  logic                                         mem3_exception_v_i,
   input  logic                                         mem3_ret_v_i,

   output logic                                         chk_dispatch_v_o,
   output logic                                         chk_roll_o,
   output logic                                         chk_psn_isd_o,
   output logic                                         chk_psn_ex_o
);

   import be_checker_pkg::*;

   logic                         isd_commit;
   logic                         chk_psn_ex;
   logic [reg_addr_width_gp-1:0] dep_rd_addr [dep_stages_gp];
   wb_class_e                    dep_class   [dep_stages_gp];
   logic [vaddr_width_p-1:0]     expected_npc;

   // Producers in flight
   be_dep_tracker u_dep_tracker (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .commit_i      (isd_commit),
      .flush_i       (chk_psn_ex),
      .rd_addr_i     (isd_rd_addr_i),
      .wb_class_i    (isd_wb_class_i),
      .dep_rd_addr_o (dep_rd_addr),
      .dep_class_o   (dep_class)
   );

   be_npc_tracker #(
      .vaddr_width_p    (vaddr_width_p),
      .pc_entry_point_p (pc_entry_point_p)
   ) u_npc_tracker (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .commit_i       (isd_commit),
      .pc_i           (isd_pc_i),
      .br_taken_i     (isd_br_taken_i),
      .br_tgt_i       (isd_br_tgt_i),
      .expected_npc_o (expected_npc)
   );

   be_detector #(
      .vaddr_width_p (vaddr_width_p)
   ) u_detector (
      .rst_n_i             (rst_n_i),
      .isd_v_i             (isd_v_i),
      .isd_pc_i            (isd_pc_i),
      .isd_irs1_v_i        (isd_irs1_v_i),
      .isd_irs2_v_i        (isd_irs2_v_i),
      .isd_frs1_v_i        (isd_frs1_v_i),
      .isd_frs2_v_i        (isd_frs2_v_i),
      .isd_rs1_addr_i      (isd_rs1_addr_i),
      .isd_rs2_addr_i      (isd_rs2_addr_i),
      .dep_rd_addr_i       (dep_rd_addr),
      .dep_class_i         (dep_class),
      .expected_npc_i      (expected_npc),
      .mmu_cmd_rdy_i       (mmu_cmd_rdy_i),
      .mem3_cache_miss_v_i (mem3_cache_miss_v_i),
      .mem3_exception_v_i  (mem3_exception_v_i),
      .mem3_ret_v_i        (mem3_ret_v_i),
      .chk_dispatch_v_o    (chk_dispatch_v_o),
      .chk_roll_o          (chk_roll_o),
      .chk_psn_isd_o       (chk_psn_isd_o),
      .chk_psn_ex_o        (chk_psn_ex),
      .isd_commit_o        (isd_commit)
   );

   // Pipe poison also clears the tracker
   assign chk_psn_ex_o = chk_psn_ex;

endmodule : be_checker_top

//--- verif/be_checker_chk.sv
// Concurrent checks on the control outputs of the issue checker
// Bound into be_checker_top by the bind statement at the end

`timescale 1ns/100ps

module be_checker_chk (
   input logic clk_i,
   input logic rst_n_i,
   input logic mmu_rdy_i,
   input logic dispatch_v_i,
   input logic roll_i,
   input logic psn_isd_i,
   input logic psn_ex_i
);

   // Count of failed assertions
   int unsigned fail_cnt = 0;

   // Replay always discards the pipe
   roll_psn_ex_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      roll_i |-> psn_ex_i)
      else begin
         $error("roll raised without pipe poison");
         fail_cnt++;
      end

   // Pipe poison covers ISD too
   psn_ex_isd_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      psn_ex_i |-> psn_isd_i)
      else begin
         $error("pipe poison raised without ISD poison");
         fail_cnt++;
      end

   // Structural hazard
   mmu_dispatch_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !mmu_rdy_i |-> !dispatch_v_i)
      else begin
         $error("dispatch allowed while MMU not ready");
         fail_cnt++;
      end

   // Both poisons held during reset
   reset_psn_a: assert property (@(posedge clk_i)
      !rst_n_i |-> (psn_isd_i && psn_ex_i))
      else begin
         $error("poison outputs inactive during reset");
         fail_cnt++;
      end

endmodule : be_checker_chk

bind be_checker_top be_checker_chk u_chk (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .mmu_rdy_i    (mmu_cmd_rdy_i),
   .dispatch_v_i (chk_dispatch_v_o),
   .roll_i       (chk_roll_o),
   .psn_isd_i    (chk_psn_isd_o),
   .psn_ex_i     (chk_psn_ex_o)
);

//--- verif/be_checker_tb.sv
// Testbench of the issue checker
// Reference model of the stage record and expected PC checks every output each cycle

`timescale 1ns/100ps

module be_checker_tb;

   import be_checker_pkg::*;

   localparam int                 vaddr_w  = 39;
   localparam logic [vaddr_w-1:0] entry_pc = 39'h8000_0000;

   logic clk;
   logic rst_n;
   logic isd_v;
   logic isd_irs1, isd_irs2, isd_frs1, isd_frs2;
   logic isd_br_taken;
   logic [vaddr_w-1:0] isd_pc, isd_br_tgt;
   logic [reg_addr_width_gp-1:0] isd_rs1, isd_rs2, isd_rd;
   wb_class_e isd_cls;
   logic mmu_rdy;
   logic mem3_miss, mem3_exc, mem3_ret;
   logic dispatch_v, roll, psn_isd, psn_ex;

   // Reference state
   wb_class_e                    model_cls [dep_stages_gp];
   logic [reg_addr_width_gp-1:0] model_rd  [dep_stages_gp];
   logic [vaddr_w-1:0]           model_npc;
   logic                         last_commit;
   int                           err_cnt;
   int                           timeout_cnt;
   string                        test_name;

   be_checker_top #(
      .vaddr_width_p    (vaddr_w),
      .pc_entry_point_p (entry_pc)
   ) uut (
      .clk_i               (clk),
      .rst_n_i             (rst_n),
      .isd_v_i             (isd_v),
      .isd_pc_i            (isd_pc),
      .isd_rs1_addr_i      (isd_rs1),
      .isd_rs2_addr_i      (isd_rs2),
      .isd_irs1_v_i        (isd_irs1),
      .isd_irs2_v_i        (isd_irs2),
      .isd_frs1_v_i        (isd_frs1),
      .isd_frs2_v_i        (isd_frs2),
      .isd_rd_addr_i       (isd_rd),
      .isd_wb_class_i      (isd_cls),
      .isd_br_taken_i      (isd_br_taken),
      .isd_br_tgt_i        (isd_br_tgt),
      .mmu_cmd_rdy_i       (mmu_rdy),
      .mem3_cache_miss_v_i (mem3_miss),
      .mem3_exception_v_i  (mem3_exc),
      .mem3_ret_v_i        (mem3_ret),
      .chk_dispatch_v_o    (dispatch_v),
      .chk_roll_o          (roll),
      .chk_psn_isd_o       (psn_isd),
      .chk_psn_ex_o        (psn_ex)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Hazard table, stage 0 is EX1
   function automatic logic blocks(input int stage, input wb_class_e cls, input logic fp_src);
      case (stage)
         0: blocks = fp_src ? (cls inside {wb_fp_mem, wb_fp_alu})
                            : (cls inside {wb_int_mul, wb_int_mem});
         1: blocks = fp_src ? (cls inside {wb_fp_mem, wb_fp_alu}) : (cls == wb_int_mem);
         default: blocks = fp_src && (cls == wb_fp_alu);
      endcase
   endfunction

   // Any read source waiting on an older producer, x0 excluded
   function automatic logic model_hazard();
      logic haz;
      haz = 1'b0;
      for (int s = 0; s < dep_stages_gp; s++) begin
         if (isd_rs1 != 0 && isd_rs1 == model_rd[s])
            haz |= (isd_irs1 && blocks(s, model_cls[s], 1'b0))
                 || (isd_frs1 && blocks(s, model_cls[s], 1'b1));
         if (isd_rs2 != 0 && isd_rs2 == model_rd[s])
            haz |= (isd_irs2 && blocks(s, model_cls[s], 1'b0))
                 || (isd_frs2 && blocks(s, model_cls[s], 1'b1));
      end
      return haz;
   endfunction

   task automatic compare(input string sig, input logic exp, input logic act);
      assert (act === exp) else begin
         $display("[ERROR] %s %s: expected %0b, actual %0b", test_name, sig, exp, act);
         err_cnt++;
      end
   endtask

   // Idle ISD, MMU ready, no late events
   task automatic put_idle();
      isd_v = 1'b0;
      isd_pc = '0;
      isd_rs1 = '0;
      isd_rs2 = '0;
      {isd_irs1, isd_irs2, isd_frs1, isd_frs2} = 4'b0000;
      isd_rd = '0;
      isd_cls = wb_none;
      isd_br_taken = 1'b0;
      isd_br_tgt = '0;
      mmu_rdy = 1'b1;
      {mem3_miss, mem3_exc, mem3_ret} = 3'b000;
   endtask

   // Instruction without sources
   task automatic put_instr(input logic [vaddr_w-1:0] pc, input logic [4:0] rd,
                            input wb_class_e cls);
      put_idle();
      isd_v = 1'b1;
      isd_pc = pc;
      isd_rd = rd;
      isd_cls = cls;
   endtask

   // Check outputs mid low phase, then advance model and clock
   task automatic step();
      logic exp_disp, exp_psn_isd, exp_psn_ex;
      #2;
      exp_psn_ex  = mem3_miss | mem3_exc | mem3_ret;
      exp_psn_isd = exp_psn_ex | (isd_v & (isd_pc != model_npc));
      exp_disp    = mmu_rdy & ~model_hazard();
      compare("dispatch", exp_disp, dispatch_v);
      compare("roll", mem3_miss, roll);
      compare("psn_isd", exp_psn_isd, psn_isd);
      compare("psn_ex", exp_psn_ex, psn_ex);
      last_commit = exp_disp & isd_v & ~exp_psn_isd;
      for (int s = dep_stages_gp - 1; s > 0; s--) begin
         model_cls[s] = exp_psn_ex ? wb_none : model_cls[s-1];
         model_rd[s]  = model_rd[s-1];
      end
      model_cls[0] = (last_commit && !exp_psn_ex) ? isd_cls : wb_none;
      model_rd[0]  = isd_rd;
      if (last_commit)
         model_npc = isd_br_taken ? isd_br_tgt : isd_pc + vaddr_w'(instr_bytes_gp);
      @(negedge clk);
   endtask

   // Hold ISD until it leaves, bounded
   task automatic issue_until_dispatch();
      int waited;
      waited = 0;
      step();
      while (!last_commit && waited < 8) begin
         waited++;
         step();
      end
      if (!last_commit) begin
         $display("Timeout in test %s: ISD instruction was never dispatched", test_name);
         timeout_cnt++;
      end
   endtask

   initial begin
      logic [4:0] r;
      void'($urandom(32'h3480));
      err_cnt = 0;
      timeout_cnt = 0;
      rst_n = 1'b0;
      put_idle();
      model_npc = entry_pc;
      for (int s = 0; s < dep_stages_gp; s++) begin
         model_cls[s] = wb_none;
         model_rd[s] = '0;
      end
      test_name = "reset";
      for (int i = 0; i < 3; i++) begin
         @(negedge clk);
         compare("psn_isd", 1'b1, psn_isd);
         compare("psn_ex", 1'b1, psn_ex);
      end
      rst_n = 1'b1;

      // Straight line, then a taken branch
      test_name = "sequential";
      put_instr(entry_pc, 5'd1, wb_int_alu);
      issue_until_dispatch();
      put_instr(entry_pc + 39'd4, 5'd2, wb_int_alu);
      isd_br_taken = 1'b1;
      isd_br_tgt = 39'h8000_0400;
      issue_until_dispatch();
      put_instr(39'h8000_0400, 5'd3, wb_int_alu);
      issue_until_dispatch();

      // Every stage, class and source kind, also against x0
      test_name = "dependency";
      for (int z = 0; z < 2; z++)
         for (int d = 1; d <= dep_stages_gp; d++)
            for (int k = 0; k < 6; k++)
               for (int s = 0; s < 4; s++) begin
                  r = (z == 1) ? 5'd0 : 5'($urandom_range(31, 1));
                  put_instr(model_npc, r, wb_class_e'(k[2:0]));
                  issue_until_dispatch();
                  put_idle();
                  for (int w = 1; w < d; w++) step();
                  put_instr(model_npc, 5'd0, wb_none);
                  isd_rs1 = r;
                  isd_rs2 = r;
                  isd_irs1 = (s == 0);
                  isd_irs2 = (s == 1);
                  isd_frs1 = (s == 2);
                  isd_frs2 = (s == 3);
                  issue_until_dispatch();
               end

      test_name = "mmu_busy";
      put_instr(model_npc, 5'd4, wb_int_alu);
      mmu_rdy = 1'b0;
      step();
      step();
      mmu_rdy = 1'b1;
      issue_until_dispatch();

      // Wrong path load leaves nothing behind
      test_name = "mispredict";
      r = 5'($urandom_range(31, 1));
      put_instr(model_npc + 39'h40, r, wb_int_mem);
      step();
      put_instr(model_npc, 5'd0, wb_none);
      isd_irs1 = 1'b1;
      isd_rs1 = r;
      issue_until_dispatch();

      // Late events drop a pending FP producer
      test_name = "mem3_flush";
      for (int s = 0; s < 3; s++) begin
         r = 5'($urandom_range(31, 1));
         put_instr(model_npc, r, wb_fp_alu);
         issue_until_dispatch();
         put_instr(model_npc, 5'd0, wb_none);
         isd_frs1 = 1'b1;
         isd_rs1 = r;
         mem3_miss = (s == 0);
         mem3_exc = (s == 1);
         mem3_ret = (s == 2);
         step();
         {mem3_miss, mem3_exc, mem3_ret} = 3'b000;
         issue_until_dispatch();
      end

      put_idle();
      step();
      $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
               err_cnt, timeout_cnt, uut.u_chk.fail_cnt);
      if (err_cnt == 0 && timeout_cnt == 0 && uut.u_chk.fail_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule : be_checker_tb

//--- be_checker_top.f
source/be_checker_pkg.sv
source/be_dep_tracker.sv
source/be_npc_tracker.sv
source/be_detector.sv
source/be_checker_top.sv
verif/be_checker_chk.sv
verif/be_checker_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the issue checker testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module be_checker_tb -f be_checker_top.f -o sim_be_checker || exit 1
out=$(./obj_dir/sim_be_checker +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
